//--- hdl/nav_pkg.sv
`default_nettype none

package nav_pkg;

	typedef logic [4:0] node_t;     // node id on the 32-node map
	typedef logic [1:0] step_t;     // leg index inside a unit route
	typedef logic [1:0] blk_loc_t;  // where the block sits

	localparam node_t home_node = 5'd0;  // start box

	// end nodes of each unit section, in visiting order
	localparam node_t [0:2] eu_route = '{
		5'd29,
		5'd27,
		5'd24
	};

	localparam node_t [0:2] cu_route = '{
		5'd7,
		5'd5,
		5'd2
	};

	localparam node_t [0:3] ru_route = '{
		5'd19,
		5'd17,
		5'd15,
		5'd12
	};

	localparam int eu_len = 3;  // legs per route
	localparam int cu_len = 3;
	localparam int ru_len = 4;

	localparam node_t [0:3] pick_nodes = '{
		5'd22,  // location 0
		5'd10,
		5'd23,
		5'd11
	};

endpackage

`default_nettype wire

//--- hdl/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

	typedef logic [3:0] addr_t;   // apb byte offset
	typedef logic [15:0] data_t;  // apb data word
	typedef logic [15:0] cyc_t;   // leg cycle count and stall limit

	typedef enum logic [1:0] {
		unit_none,
		unit_eu,
		unit_cu,
		unit_ru
	} unit_e;

	typedef enum logic [2:0] {
		st_idle,
		st_homing,
		st_scan,
		st_pick,
		st_rectify
	} state_e;

	typedef struct packed {
		logic           cpu_start;    // high for the whole leg
		nav_pkg::node_t start_point;
		nav_pkg::node_t end_point;
	} path_req_t;

	typedef struct packed {
		logic  psel;
		logic  penable;
		logic  pwrite;
		addr_t paddr;
		data_t pwdata;
	} apb_req_t;

	typedef struct packed {
		data_t prdata;
		logic  pready;
		logic  pslverr;
	} apb_rsp_t;

	localparam addr_t reg_ctrl = 4'h0;    // bit0 enable, bit1 stall clear
	localparam addr_t reg_status = 4'h4;  // state, all_done, stall
	localparam addr_t reg_legs = 4'h8;
	localparam addr_t reg_limit = 4'hC;

	localparam cyc_t limit_reset = 16'd1000;

endpackage

`default_nettype wire

//--- hdl/waypoint_rom.sv
`default_nettype none

module waypoint_rom (
	input  ctrl_pkg::unit_e   unit,
	input  nav_pkg::step_t    step,
	input  logic              pick_sel,
	input  logic              homing,
	input  nav_pkg::blk_loc_t block_location,
	output nav_pkg::node_t    target
);

	nav_pkg::node_t route_node;

	// node of the current leg inside the unit section
	always_comb begin
		route_node = nav_pkg::home_node;
		case (unit)
			ctrl_pkg::unit_eu: begin
				if (int'(step) < nav_pkg::eu_len) begin
					route_node = nav_pkg::eu_route[step];
				end
			end
			ctrl_pkg::unit_cu: begin
				if (int'(step) < nav_pkg::cu_len) begin
					route_node = nav_pkg::cu_route[step];
				end
			end
			ctrl_pkg::unit_ru: begin
				route_node = nav_pkg::ru_route[step];  // four legs cover every step
			end
			default: begin
				route_node = nav_pkg::home_node;
			end
		endcase
	end

	always_comb begin
		if (homing) begin
			target = nav_pkg::home_node;
		end else if (pick_sel) begin
			target = nav_pkg::pick_nodes[block_location];
		end else begin
			target = route_node;
		end
	end

endmodule

`default_nettype wire

//--- hdl/leg_timer.sv
`default_nettype none

module leg_timer (
	input  logic           clk_3125KHz,
	input  logic           rst_n,
	input  logic           leg_active,
	input  ctrl_pkg::cyc_t stall_limit,
	input  logic           stall_clr,
	output logic           stall
);

	ctrl_pkg::cyc_t count;  // cycles spent in the running leg

	always_ff @(posedge clk_3125KHz or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
		end else if (!leg_active) begin
			count <= '0;  // restart for the next leg
		end else if (count != '1) begin
			count <= count + 16'd1;  // hold at max on very long legs
		end
	end

	always_ff @(posedge clk_3125KHz or negedge rst_n) begin
		if (!rst_n) begin
			stall <= 1'b0;
		end else if (stall_clr) begin
			stall <= 1'b0;
		end else if (leg_active && (count == stall_limit)) begin
			stall <= 1'b1;  // sticky while the leg itself goes on
		end
	end

endmodule

`default_nettype wire

//--- hdl/mission_fsm.sv
`default_nettype none

module mission_fsm (
	input  logic                clk_3125KHz,
	input  logic                rst_n,
	input  logic                enable,
	input  logic                eu_fault,
	input  logic                cu_fault,
	input  logic                ru_fault,
	input  logic                pick_block,
	input  nav_pkg::node_t      realtime_pos,
	input  nav_pkg::node_t      target,
	output ctrl_pkg::unit_e     unit,
	output nav_pkg::step_t      step,
	output logic                pick_sel,
	output ctrl_pkg::path_req_t path_req,
	output logic                leg_active,
	output logic                leg_done,
	output ctrl_pkg::state_e    state,
	output logic                all_done
);

	logic arrive;     // bot sits on the latched end node
	logic last_step;  // current leg closes the unit route
	logic leg_req;    // state wants a new leg issued

	function automatic int route_len(ctrl_pkg::unit_e u);
		case (u)
			ctrl_pkg::unit_eu: return nav_pkg::eu_len;
			ctrl_pkg::unit_cu: return nav_pkg::cu_len;
			ctrl_pkg::unit_ru: return nav_pkg::ru_len;
			default: return 0;
		endcase
	endfunction

	assign leg_active = path_req.cpu_start;
	assign pick_sel = (state == ctrl_pkg::st_pick);
	assign arrive = leg_active && (realtime_pos == path_req.end_point);
	assign last_step = (int'(step) == route_len(unit) - 1);

	always_comb begin
		case (state)
			ctrl_pkg::st_homing,
			ctrl_pkg::st_scan,
			ctrl_pkg::st_rectify: leg_req = 1'b1;
			ctrl_pkg::st_pick: leg_req = pick_block;  // wait for the pickup command
			default: leg_req = 1'b0;
		endcase
	end

	always_ff @(posedge clk_3125KHz or negedge rst_n) begin
		if (!rst_n) begin
			state <= ctrl_pkg::st_idle;
			unit <= ctrl_pkg::unit_none;
			step <= '0;
			path_req <= '0;
			leg_done <= 1'b0;
			all_done <= 1'b0;
		end else begin
			leg_done <= 1'b0;
			if (!enable) begin
				all_done <= 1'b0;  // everything else holds
			end else begin
				if (leg_active) begin
					path_req.start_point <= realtime_pos;
				end
				if (arrive) begin
					path_req.cpu_start <= 1'b0;
					leg_done <= 1'b1;
					case (state)
						ctrl_pkg::st_homing: begin
							state <= ctrl_pkg::st_idle;
							all_done <= 1'b1;
						end
						ctrl_pkg::st_scan: begin
							if (last_step) begin
								step <= '0;
								state <= ctrl_pkg::st_pick;
							end else begin
								step <= step + 2'd1;
							end
						end
						ctrl_pkg::st_pick: begin
							step <= '0;
							state <= ctrl_pkg::st_rectify;  // replay the same unit route
						end
						ctrl_pkg::st_rectify: begin
							if (last_step) begin
								step <= '0;
								unit <= ctrl_pkg::unit_none;
								state <= ctrl_pkg::st_idle;
							end else begin
								step <= step + 2'd1;
							end
						end
						default: begin
							state <= ctrl_pkg::st_idle;
						end
					endcase
				end else if (!leg_active) begin
					if (state == ctrl_pkg::st_idle) begin
						step <= '0;
						if (eu_fault) begin  // eu over cu over ru
							unit <= ctrl_pkg::unit_eu;
							state <= ctrl_pkg::st_scan;
						end else if (cu_fault) begin
							unit <= ctrl_pkg::unit_cu;
							state <= ctrl_pkg::st_scan;
						end else if (ru_fault) begin
							unit <= ctrl_pkg::unit_ru;
							state <= ctrl_pkg::st_scan;
						end else if (realtime_pos != nav_pkg::home_node) begin
							state <= ctrl_pkg::st_homing;
						end
					end else if (leg_req) begin
						path_req.cpu_start <= 1'b1;
						path_req.start_point <= realtime_pos;
						path_req.end_point <= target;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/mission_regs.sv
`default_nettype none

module mission_regs (
	input  logic               clk_3125KHz,
	input  logic               rst_n,
	input  ctrl_pkg::apb_req_t apb_req,
	output ctrl_pkg::apb_rsp_t apb_rsp,
	output logic               enable,
	output logic               stall_clr,
	output ctrl_pkg::cyc_t     stall_limit,
	input  ctrl_pkg::state_e   state,
	input  logic               all_done,
	input  logic               stall,
	input  logic               leg_done
);

	logic            access;   // apb access phase
	logic            addr_ok;
	logic            wr_en;
	ctrl_pkg::data_t rd_data;
	ctrl_pkg::data_t leg_count;

	assign access = apb_req.psel && apb_req.penable;
	assign wr_en = access && apb_req.pwrite && addr_ok;

	always_comb begin
		addr_ok = 1'b1;
		case (apb_req.paddr)
			ctrl_pkg::reg_ctrl: rd_data = {15'd0, enable};
			ctrl_pkg::reg_status: rd_data = {11'd0, stall, all_done, state};
			ctrl_pkg::reg_legs: rd_data = leg_count;
			ctrl_pkg::reg_limit: rd_data = stall_limit;
			default: begin
				addr_ok = 1'b0;
				rd_data = '0;
			end
		endcase
	end

	always_comb begin
		apb_rsp.prdata = (access && !apb_req.pwrite) ? rd_data : '0;
		apb_rsp.pready = 1'b1;  // no wait states
		apb_rsp.pslverr = access && !addr_ok;
	end

	always_ff @(posedge clk_3125KHz or negedge rst_n) begin
		if (!rst_n) begin
			enable <= 1'b0;
			stall_clr <= 1'b0;
			stall_limit <= ctrl_pkg::limit_reset;
		end else begin
			stall_clr <= 1'b0;  // one cycle pulse
			if (wr_en && (apb_req.paddr == ctrl_pkg::reg_ctrl)) begin
				enable <= apb_req.pwdata[0];
				stall_clr <= apb_req.pwdata[1];
			end
			if (wr_en && (apb_req.paddr == ctrl_pkg::reg_limit)) begin
				stall_limit <= apb_req.pwdata;
			end
		end
	end

	always_ff @(posedge clk_3125KHz or negedge rst_n) begin
		if (!rst_n) begin
			leg_count <= '0;
		end else if (wr_en && (apb_req.paddr == ctrl_pkg::reg_legs)) begin
			leg_count <= '0;  // any write clears
		end else if (leg_done) begin
			leg_count <= leg_count + 16'd1;  // wraps
		end
	end

endmodule

`default_nettype wire

//--- hdl/mission_ctrl_top.sv
`default_nettype none

module mission_ctrl_top (
	input  logic                clk_3125KHz,
	input  logic                rst_n,
	input  ctrl_pkg::apb_req_t  apb_req,
	output ctrl_pkg::apb_rsp_t  apb_rsp,
	input  logic                eu_fault,
	input  logic                cu_fault,
	input  logic                ru_fault,
	input  logic                pick_block,
	input  nav_pkg::blk_loc_t   block_location,
	input  nav_pkg::node_t      realtime_pos,
	output ctrl_pkg::path_req_t path_req,
	output logic                all_done
);

	logic             enable;
	logic             stall_clr;
	logic             stall;
	logic             leg_active;
	logic             leg_done;
	logic             pick_sel;
	ctrl_pkg::cyc_t   stall_limit;
	ctrl_pkg::state_e state;
	ctrl_pkg::unit_e  unit;
	nav_pkg::step_t   step;
	nav_pkg::node_t   target;

	mission_regs u_regs (
		.clk_3125KHz (clk_3125KHz),
		.rst_n       (rst_n),
		.apb_req     (apb_req),
		.apb_rsp     (apb_rsp),
		.enable      (enable),
		.stall_clr   (stall_clr),
		.stall_limit (stall_limit),
		.state       (state),
		.all_done    (all_done),
		.stall       (stall),
		.leg_done    (leg_done)
	);

	mission_fsm u_fsm (
		.clk_3125KHz  (clk_3125KHz),
		.rst_n        (rst_n),
		.enable       (enable),
		.eu_fault     (eu_fault),
		.cu_fault     (cu_fault),
		.ru_fault     (ru_fault),
		.pick_block   (pick_block),
		.realtime_pos (realtime_pos),
		.target       (target),
		.unit         (unit),
		.step         (step),
		.pick_sel     (pick_sel),
		.path_req     (path_req),
		.leg_active   (leg_active),
		.leg_done     (leg_done),
		.state        (state),
		.all_done     (all_done)
	);

	waypoint_rom u_rom (
		.unit           (unit),
		.step           (step),
		.pick_sel       (pick_sel),
		.homing         (state == ctrl_pkg::st_homing),
		.block_location (block_location),
		.target         (target)
	);

	leg_timer u_timer (
		.clk_3125KHz (clk_3125KHz),
		.rst_n       (rst_n),
		.leg_active  (leg_active),
		.stall_limit (stall_limit),
		.stall_clr   (stall_clr),
		.stall       (stall)
	);

endmodule

`default_nettype wire

//--- dv/mission_ctrl_assert.sv
`default_nettype none

module mission_ctrl_assert (
	input logic                clk_3125KHz,
	input logic                rst_n,
	input ctrl_pkg::path_req_t path_req,
	input logic                leg_done,
	input nav_pkg::node_t      realtime_pos,
	input logic                all_done,
	input ctrl_pkg::apb_req_t  apb_req,
	input ctrl_pkg::apb_rsp_t  apb_rsp
);

	int stable_fails = 0;
	int arrive_fails = 0;
	int ready_fails = 0;
	int done_fails = 0;
	int fail_total;

	assign fail_total = stable_fails + arrive_fails + ready_fails + done_fails;

	// fsm path request
	end_point_stable: assert property (@(posedge clk_3125KHz) disable iff (!rst_n)
		(path_req.cpu_start && $past(path_req.cpu_start)) |-> $stable(path_req.end_point))
		else begin
			stable_fails = stable_fails + 1;
			$error("end_point changed during an active leg");
		end

	done_at_end_node: assert property (@(posedge clk_3125KHz) disable iff (!rst_n)
		leg_done |-> (realtime_pos == path_req.end_point))
		else begin
			arrive_fails = arrive_fails + 1;
			$error("leg_done while the bot is off the end node");
		end

	// regs apb response
	ready_in_access: assert property (@(posedge clk_3125KHz) disable iff (!rst_n)
		(apb_req.psel && apb_req.penable) |-> apb_rsp.pready)
		else begin
			ready_fails = ready_fails + 1;
			$error("pready low in an access cycle");
		end

	done_low_after_reset: assert property (@(posedge clk_3125KHz)
		$rose(rst_n) |-> !all_done)
		else begin
			done_fails = done_fails + 1;
			$error("all_done high right after reset");
		end

endmodule

bind mission_ctrl_top mission_ctrl_assert u_assert (
	.clk_3125KHz  (clk_3125KHz),
	.rst_n        (rst_n),
	.path_req     (path_req),
	.leg_done     (leg_done),
	.realtime_pos (realtime_pos),
	.all_done     (all_done),
	.apb_req      (apb_req),
	.apb_rsp      (apb_rsp)
);

`default_nettype wire

//--- dv/mission_ctrl_tb.sv
`default_nettype none

module mission_ctrl_tb;

	typedef nav_pkg::node_t node_q_t [$];

	// 12 missions of route, pickup and replay, one homing leg after each, plus the first homing
	localparam int total_legs = 4 * (2 * (3 + 3 + 4) + 3) + 12 + 1;
	localparam int cycle_limit = total_legs * 20 + 2000;

	logic                clk_3125KHz = 1'b0;
	logic                rst_n;
	ctrl_pkg::apb_req_t  apb_req;
	ctrl_pkg::apb_rsp_t  apb_rsp;
	logic                eu_fault;
	logic                cu_fault;
	logic                ru_fault;
	logic                pick_block;
	nav_pkg::blk_loc_t   block_location;
	nav_pkg::node_t      realtime_pos;
	ctrl_pkg::path_req_t path_req;
	logic                all_done;

	logic [31:0]     lfsr = 32'd94243;
	int              bot_delay;
	int              bot_hold = 0;  // extra cycles before the bot moves
	logic            leg_served = 1'b0;
	node_q_t         exp_q;  // end nodes in request order
	int              exp_idx = 0;
	logic            start_seen = 1'b0;
	nav_pkg::node_t  prev_pos;  // bot position seen at the previous edge
	int              cycle_count = 0;
	ctrl_pkg::data_t rd_data;
	logic            slverr;

	always #4 clk_3125KHz = ~clk_3125KHz;

	mission_ctrl_top DUT (
		.clk_3125KHz    (clk_3125KHz),
		.rst_n          (rst_n),
		.apb_req        (apb_req),
		.apb_rsp        (apb_rsp),
		.eu_fault       (eu_fault),
		.cu_fault       (cu_fault),
		.ru_fault       (ru_fault),
		.pick_block     (pick_block),
		.block_location (block_location),
		.realtime_pos   (realtime_pos),
		.path_req       (path_req),
		.all_done       (all_done)
	);

	// route of the unit, the pickup node, then the same route again
	function automatic node_q_t expected_route(ctrl_pkg::unit_e unit, nav_pkg::blk_loc_t loc);
		nav_pkg::node_t eu_nodes [3] = '{5'd29, 5'd27, 5'd24};
		nav_pkg::node_t cu_nodes [3] = '{5'd7, 5'd5, 5'd2};
		nav_pkg::node_t ru_nodes [4] = '{5'd19, 5'd17, 5'd15, 5'd12};
		nav_pkg::node_t pickups [4] = '{5'd22, 5'd10, 5'd23, 5'd11};
		node_q_t route;
		node_q_t nodes;
		case (unit)
			ctrl_pkg::unit_eu: foreach (eu_nodes[i]) route.push_back(eu_nodes[i]);
			ctrl_pkg::unit_cu: foreach (cu_nodes[i]) route.push_back(cu_nodes[i]);
			ctrl_pkg::unit_ru: foreach (ru_nodes[i]) route.push_back(ru_nodes[i]);
			default: route.delete();
		endcase
		nodes = route;
		nodes.push_back(pickups[loc]);
		foreach (route[i]) nodes.push_back(route[i]);
		return nodes;
	endfunction

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'hD000_0001;
		end else begin
			return s >> 1;
		end
	endfunction

	task automatic draw_delay(output int d);
		d = 0;
		for (int i = 0; i < 3; i++) begin
			lfsr = lfsr_next(lfsr);  // one step per bit
			d = d * 2 + (lfsr[0] ? 1 : 0);
		end
	endtask

	task automatic stop_on_failure(input string reason);
		$display("%s", reason);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			stop_on_failure($sformatf("** Error: %s got 0x%0h, expected 0x%0h", name, got, exp));
		end
	endtask

	task automatic apb_access(input logic write, input ctrl_pkg::addr_t addr,
		input ctrl_pkg::data_t wdata, output ctrl_pkg::data_t rdata, output logic err);
		ctrl_pkg::apb_req_t req;
		req = '0;
		req.psel = 1'b1;
		req.pwrite = write;
		req.paddr = addr;
		req.pwdata = wdata;
		@(posedge clk_3125KHz);
		apb_req <= req;  // setup
		req.penable = 1'b1;
		@(posedge clk_3125KHz);
		apb_req <= req;  // access
		@(posedge clk_3125KHz);
		rdata = apb_rsp.prdata;
		err = apb_rsp.pslverr;
		apb_req <= '0;
	endtask

	task automatic apb_write(input ctrl_pkg::addr_t addr, input ctrl_pkg::data_t data,
		output logic err);
		ctrl_pkg::data_t unused;
		apb_access(1'b1, addr, data, unused, err);
	endtask

	task automatic apb_read(input ctrl_pkg::addr_t addr, output ctrl_pkg::data_t data,
		output logic err);
		apb_access(1'b0, addr, 16'h0000, data, err);
	endtask

	task automatic expect_reg(input ctrl_pkg::addr_t addr, input ctrl_pkg::data_t exp,
		input string name);
		ctrl_pkg::data_t data;
		logic err;
		apb_read(addr, data, err);
		check_value("pslverr", 32'(err), 32'd0);
		check_value(name, 32'(data), 32'(exp));
	endtask

	task automatic wait_all_done();
		do @(posedge clk_3125KHz); while (!all_done);
	endtask

	task automatic run_mission(input ctrl_pkg::unit_e unit, input nav_pkg::blk_loc_t loc);
		node_q_t route;
		apb_write(ctrl_pkg::reg_ctrl, 16'h0000, slverr);  // drops all_done
		apb_write(ctrl_pkg::reg_legs, 16'h0000, slverr);
		route = expected_route(unit, loc);
		foreach (route[i]) exp_q.push_back(route[i]);
		exp_q.push_back(5'd0);  // homing leg that follows the mission
		@(posedge clk_3125KHz);
		eu_fault <= (unit == ctrl_pkg::unit_eu);
		cu_fault <= (unit == ctrl_pkg::unit_cu);
		ru_fault <= (unit == ctrl_pkg::unit_ru);
		block_location <= loc;
		pick_block <= 1'b1;
		apb_write(ctrl_pkg::reg_ctrl, 16'h0001, slverr);
		do @(posedge clk_3125KHz); while (!path_req.cpu_start);
		eu_fault <= 1'b0;  // unit is stored so the fault can go
		cu_fault <= 1'b0;
		ru_fault <= 1'b0;
		wait_all_done();
		check_value("pending legs", 32'(exp_q.size() - exp_idx), 32'd0);
		expect_reg(ctrl_pkg::reg_legs, 16'(route.size() + 1), "legs");
		expect_reg(ctrl_pkg::reg_status, 16'h0008, "status");
		pick_block <= 1'b0;
	endtask

	// bot model that moves onto the end node after a random delay
	initial begin
		realtime_pos = 5'd13;
		forever begin
			@(posedge clk_3125KHz);
			if (rst_n && path_req.cpu_start && !leg_served) begin
				leg_served = 1'b1;
				draw_delay(bot_delay);
				repeat (bot_delay + bot_hold) @(posedge clk_3125KHz);
				realtime_pos <= path_req.end_point;
			end else if (!path_req.cpu_start) begin
				leg_served = 1'b0;
			end
		end
	end

	// compare each new request with the next expected node
	always @(posedge clk_3125KHz) begin
		if (rst_n && path_req.cpu_start) begin
			check_value("start_point", 32'(path_req.start_point), 32'(prev_pos));  // one cycle behind
		end
		if (rst_n && path_req.cpu_start && !start_seen) begin
			if (exp_idx >= exp_q.size()) begin
				stop_on_failure($sformatf("unexpected path request to node %0d",
					path_req.end_point));
			end else begin
				check_value("end_point", 32'(path_req.end_point), 32'(exp_q[exp_idx]));
				exp_idx = exp_idx + 1;
			end
		end
		start_seen <= path_req.cpu_start;
		prev_pos <= realtime_pos;
	end

	always @(posedge clk_3125KHz) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			stop_on_failure("timeout: the missions did not finish within the cycle limit");
		end
	end

	initial begin
		rst_n = 1'b0;
		apb_req = '0;
		eu_fault = 1'b0;
		cu_fault = 1'b0;
		ru_fault = 1'b0;
		pick_block = 1'b0;
		block_location = 2'd0;
		repeat (10) @(posedge clk_3125KHz);
		rst_n <= 1'b1;
		expect_reg(ctrl_pkg::reg_status, 16'h0000, "status");
		expect_reg(ctrl_pkg::reg_ctrl, 16'h0000, "ctrl");
		repeat (20) begin
			@(posedge clk_3125KHz);
			check_value("cpu_start", 32'(path_req.cpu_start), 32'd0);  // disabled while off home
		end
		apb_write(4'h2, 16'hFFFF, slverr);
		check_value("pslverr", 32'(slverr), 32'd1);
		apb_read(4'h6, rd_data, slverr);
		check_value("pslverr", 32'(slverr), 32'd1);
		expect_reg(ctrl_pkg::reg_ctrl, 16'h0000, "ctrl");
		expect_reg(ctrl_pkg::reg_limit, 16'd1000, "limit");
		// homing with a slow bot and a short stall limit
		bot_hold = 10;
		apb_write(ctrl_pkg::reg_limit, 16'd4, slverr);
		exp_q.push_back(5'd0);
		apb_write(ctrl_pkg::reg_ctrl, 16'h0001, slverr);
		wait_all_done();
		expect_reg(ctrl_pkg::reg_status, 16'h0018, "status");
		apb_write(ctrl_pkg::reg_ctrl, 16'h0003, slverr);
		expect_reg(ctrl_pkg::reg_status, 16'h0008, "status");
		bot_hold = 0;
		apb_write(ctrl_pkg::reg_limit, 16'd1000, slverr);
		for (int u = 1; u < 4; u++) begin
			for (int loc = 0; loc < 4; loc++) begin
				run_mission(ctrl_pkg::unit_e'(u), nav_pkg::blk_loc_t'(loc));
			end
		end
		if (DUT.u_assert.fail_total == 0) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			stop_on_failure("concurrent assertions reported failures");
		end
	end

endmodule

`default_nettype wire

//--- mission_ctrl_top.f
hdl/nav_pkg.sv
hdl/ctrl_pkg.sv
hdl/waypoint_rom.sv
hdl/leg_timer.sv
hdl/mission_fsm.sv
hdl/mission_regs.sv
hdl/mission_ctrl_top.sv
dv/mission_ctrl_assert.sv
dv/mission_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module mission_ctrl_tb \
	-f mission_ctrl_top.f -o mission_ctrl_sim || exit 1
out=$(./obj_dir/mission_ctrl_sim +verilator+error+limit+100 2>&1)
echo "$out"
echo "$out" | grep -qF '*** TEST PASSED ***' && echo "simulation passed" || {
	echo "simulation failed"
	exit 1
}
